//--- tb/soc_bus_golden.txt
# port op addr wdata wstrb chk exp_a exp_b (L load/store, I fetch, P load+fetch, Q irq, D byte)
# chk: 0 none, 1 exact, 2 above previous read, 3 stall until FIFO drains; P fetch addr in wdata
L W 00000100 11223344 f 0 00000000 00000000
L W 00000100 aabbccdd 5 0 00000000 00000000
L R 00000100 00000000 0 1 11bb33dd 00000000
I R 00000100 00000000 0 1 11bb33dd 00000000
L W 00000200 cafef00d f 0 00000000 00000000
L W 00000204 0badbeef f 0 00000000 00000000
P R 00000200 00000204 0 1 cafef00d 0badbeef
L W a0000050 12345678 f 0 00000000 00000000
L W a0000054 00abcdef f 0 00000000 00000000
L R a0000050 00000000 0 1 12345678 00000000
L R a0000054 00000000 0 1 00abcdef 00000000
L R a0000048 00000000 0 0 00000000 00000000
L R a0000048 00000000 0 2 00000000 00000000
L W a0000050 00000000 f 0 00000000 00000000
L W a0000054 00000000 f 0 00000000 00000000
Q R 00000000 00000000 0 0 00000001 00000000
L W a0000054 ffffffff f 0 00000000 00000000
Q R 00000000 00000000 0 0 00000000 00000000
L W a0000050 ffffffff f 0 00000000 00000000
L W a00003f8 00000041 1 0 00000000 00000000
L W a00003f8 00000042 1 0 00000000 00000000
L W a00003f8 00000043 1 0 00000000 00000000
L W a00003f8 00000044 1 0 00000000 00000000
L W a00003f8 00000045 1 3 00000000 00000000
D R 00000000 00000000 0 1 00000041 00000000
D R 00000000 00000000 0 1 00000042 00000000
D R 00000000 00000000 0 1 00000043 00000000
D R 00000000 00000000 0 1 00000044 00000000
D R 00000000 00000000 0 1 00000045 00000000

//--- all.f
design/bus_pkg.sv
design/map_pkg.sv
design/bus_arbiter.sv
design/clint_timer.sv
design/uart_tx_buffer.sv
design/soc_bus_top.sv
tb/soc_bus_asserts.sv
tb/soc_bus_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench; status follows the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module soc_bus_tb -f all.f -o soc_bus_sim &&
./obj_dir/soc_bus_sim | tee /dev/stderr | grep -qx "sim passed" &&
echo "run ok" ||
{ echo "run failed"; exit 1; }

//--- tb/soc_bus_tb.sv
module soc_bus_tb;

  localparam int RSP_TIMEOUT   = 100;
  localparam int STALL_CYCLES  = 16;
  localparam int DRAIN_TIMEOUT = 50;
  localparam int IRQ_WINDOW    = 2;

  logic              clk;
  logic              rst;
  logic              ifu_req_valid_i;
  logic [31:0]       ifu_addr_i;
  logic              ifu_req_ready_o;
  logic              ifu_rsp_valid_o;
  bus_pkg::bus_rsp_t ifu_rsp_o;
  logic              lsu_req_valid_i;
  bus_pkg::bus_req_t lsu_req_i;
  logic              lsu_req_ready_o;
  logic              lsu_rsp_valid_o;
  bus_pkg::bus_rsp_t lsu_rsp_o;
  logic              mem_req_valid_o;
  bus_pkg::bus_req_t mem_req_o;
  logic              mem_req_ready_i;
  logic              mem_rsp_valid_i;
  bus_pkg::bus_rsp_t mem_rsp_i;
  logic              uart_tx_valid_o;
  logic [7:0]        uart_tx_data_o;
  logic              uart_tx_ready_i;
  logic              timer_irq_o;

  int          errors;
  int          checks;
  logic [31:0] prev_rd;
  logic [31:0] mem_words [logic [29:0]];
  logic [7:0]  tx_bytes [$];

  // memory model state
  logic        rsp_pending;
  int          rsp_delay;
  int          ready_delay;
  logic [31:0] rsp_data;

  soc_bus_top soc_bus_top_inst (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // unwritten words read back a pattern of their own address
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem_words.exists(addr[31:2]))
      return mem_words[addr[31:2]];
    return {addr[31:16] ^ addr[15:0], addr[15:0]} ^ 32'h5a5a_a5a5;
  endfunction

  task automatic serve_mem(input bus_pkg::bus_req_t req);
    logic [31:0] word;
    word = read_word(req.addr);
    if (req.op == bus_pkg::OP_WRITE)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (req.wstrb[i])
          word[8*i +: 8] = req.wdata[8*i +: 8];
      end
      mem_words[req.addr[31:2]] = word;
      rsp_data = 32'd0;
    end
    else
      rsp_data = word;
  endtask

  // external memory with random ready and response delays of 0 to 3 cycles
  always @(negedge clk)
  begin
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    if (rst)
    begin
      rsp_pending = 1'b0;
      ready_delay = 0;
    end
    else if (rsp_pending)
    begin
      if (rsp_delay == 0)
      begin
        mem_rsp_valid_i = 1'b1;
        mem_rsp_i.rdata = rsp_data;
        rsp_pending     = 1'b0;
      end
      else
        rsp_delay--;
    end
    else if (mem_req_valid_o)
    begin
      if (ready_delay == 0)
      begin
        mem_req_ready_i = 1'b1;
        serve_mem(mem_req_o);
        rsp_pending = 1'b1;
        rsp_delay   = $urandom % 4;
        ready_delay = $urandom % 4;
      end
      else
        ready_delay--;
    end
  end

  // serial bytes leaving the DUT in order
  always @(negedge clk)
  begin
    #1;
    if (!rst && uart_tx_valid_o && uart_tx_ready_i)
      tx_bytes.push_back(uart_tx_data_o);
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("ERROR t=%0t %s exp=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic check_lsu_rsp(input int chk, input logic [31:0] exp, input logic is_read);
    if (chk == 1)
      check_value("lsu_rsp_o", exp, lsu_rsp_o.rdata);
    if (chk == 2)
    begin
      checks++;
      assert (lsu_rsp_o.rdata > prev_rd)
      else
      begin
        errors++;
        $display("ERROR t=%0t lsu_rsp_o exp>%h got=%h", $time, prev_rd, lsu_rsp_o.rdata);
      end
    end
    if (is_read)
      prev_rd = lsu_rsp_o.rdata;
    // writes answer with zero data
    else
      check_value("lsu_rsp_o", 32'd0, lsu_rsp_o.rdata);
  endtask

  // hold a serial write against a full FIFO and then let the FIFO drain
  task automatic hold_stalled_write();
    for (int n = 0; n < STALL_CYCLES; n++)
    begin
      #1;
      checks++;
      assert (!lsu_req_ready_o)
      else
      begin
        errors++;
        $display("ERROR t=%0t lsu_req_ready_o exp=0 got=1", $time);
      end
      @(negedge clk);
    end
    $display("serial write held for %0d cycles, releasing uart_tx_ready_i", STALL_CYCLES);
    uart_tx_ready_i = 1'b1;
  endtask

  task automatic run_access(input logic use_l, input logic use_i,
                            input bus_pkg::bus_req_t lreq, input logic [31:0] iaddr,
                            input int chk, input logic [31:0] exp_l,
                            input logic [31:0] exp_i);
    logic got_l;
    logic got_i;
    logic l_acc;
    logic i_acc;
    int   n;
    @(negedge clk);
    lsu_req_valid_i = use_l;
    lsu_req_i       = lreq;
    ifu_req_valid_i = use_i;
    ifu_addr_i      = iaddr;
    if (chk == 3)
      hold_stalled_write();
    got_l = !use_l;
    got_i = !use_i;
    n     = 0;
    while (!(got_l && got_i) && n < RSP_TIMEOUT)
    begin
      #1;
      if (lsu_rsp_valid_o && !got_l)
      begin
        got_l = 1'b1;
        check_lsu_rsp(chk, exp_l, lreq.op == bus_pkg::OP_READ);
      end
      if (ifu_rsp_valid_o && !got_i)
      begin
        checks++;
        assert (got_l)
        else
        begin
          errors++;
          $display("fetch response came before the load response at t=%0t", $time);
        end
        got_i = 1'b1;
        if (chk == 1)
          check_value("ifu_rsp_o", exp_i, ifu_rsp_o.rdata);
      end
      l_acc = lsu_req_valid_i && lsu_req_ready_o;
      i_acc = ifu_req_valid_i && ifu_req_ready_o;
      @(negedge clk);
      if (l_acc)
        lsu_req_valid_i = 1'b0;
      if (i_acc)
        ifu_req_valid_i = 1'b0;
      n++;
    end
    checks++;
    assert (got_l && got_i)
    else
    begin
      errors++;
      $display("timed out waiting for a bus response at t=%0t", $time);
    end
  endtask

  task automatic check_irq(input logic exp);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < IRQ_WINDOW && !seen; n++)
    begin
      @(negedge clk);
      #1;
      if (timer_irq_o == exp)
        seen = 1'b1;
    end
    checks++;
    assert (seen)
    else
    begin
      errors++;
      $display("ERROR t=%0t timer_irq_o exp=%0b got=%0b", $time, exp, timer_irq_o);
    end
  endtask

  task automatic check_byte(input logic [7:0] exp);
    int n;
    n = 0;
    while (tx_bytes.size() == 0 && n < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (tx_bytes.size() != 0)
    else
    begin
      errors++;
      $display("timed out waiting for a serial byte at t=%0t", $time);
    end
    if (tx_bytes.size() != 0)
      check_value("uart_tx_data_o", {24'd0, exp}, {24'd0, tx_bytes.pop_front()});
  endtask

  initial
  begin
    int                fd;
    int                cnt;
    int                chk;
    string             line;
    logic [7:0]        port_c;
    logic [7:0]        op_c;
    logic [31:0]       addr;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic [31:0]       exp_a;
    logic [31:0]       exp_b;
    bus_pkg::bus_req_t req;
    void'($urandom(32'ha2f75321));
    errors          = 0;
    checks          = 0;
    prev_rd         = 32'd0;
    rst             = 1'b1;
    ifu_req_valid_i = 1'b0;
    ifu_addr_i      = 32'd0;
    lsu_req_valid_i = 1'b0;
    lsu_req_i       = '0;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    uart_tx_ready_i = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fd = $fopen("tb/soc_bus_golden.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the golden data file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#")
          continue;
        cnt = $sscanf(line, "%c %c %h %h %h %d %h %h",
                      port_c, op_c, addr, wdata, wstrb, chk, exp_a, exp_b);
        if (cnt != 8)
        begin
          errors++;
          $display("malformed golden line: %s", line);
          continue;
        end
        req.op    = (op_c == "W") ? bus_pkg::OP_WRITE : bus_pkg::OP_READ;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = wstrb;
        case (port_c)
          "L": run_access(1'b1, 1'b0, req, 32'd0, chk, exp_a, 32'd0);
          "I": run_access(1'b0, 1'b1, req, addr, chk, 32'd0, exp_a);
          // fetch address rides in the wdata column
          "P": run_access(1'b1, 1'b1, req, wdata, chk, exp_a, exp_b);
          "Q": check_irq(exp_a[0]);
          "D": check_byte(exp_a[7:0]);
          default:
          begin
            errors++;
            $display("unknown port in golden line: %s", line);
          end
        endcase
      end
      $fclose(fd);
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- tb/soc_bus_asserts.sv
module soc_bus_asserts (
  input logic              clk,
  input logic              rst,
  input logic              mem_req_valid_o,
  input logic              mem_req_ready_i,
  input bus_pkg::bus_req_t mem_req_o,
  input logic              lsu_rsp_valid_o,
  input logic              ifu_rsp_valid_o,
  input logic              uart_tx_valid_o,
  input logic              uart_tx_ready_i,
  input logic [7:0]        uart_tx_data_o
);

  // memory request held with its payload until taken
  mem_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else $error("mem_req_o dropped or changed before mem_req_ready_i");

  // one owner per response
  rsp_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(lsu_rsp_valid_o && ifu_rsp_valid_o))
    else $error("lsu_rsp_valid_o and ifu_rsp_valid_o high together");

  uart_tx_hold: assert property (@(posedge clk) disable iff (rst)
    uart_tx_valid_o && !uart_tx_ready_i |=> uart_tx_valid_o && $stable(uart_tx_data_o))
    else $error("uart_tx_data_o dropped or changed before uart_tx_ready_i");

endmodule

bind soc_bus_top soc_bus_asserts soc_bus_asserts_inst (.*);

//--- design/soc_bus_top.sv
module soc_bus_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              ifu_req_valid_i,
  input  logic [31:0]       ifu_addr_i,
  output logic              ifu_req_ready_o,
  output logic              ifu_rsp_valid_o,
  output bus_pkg::bus_rsp_t ifu_rsp_o,
  input  logic              lsu_req_valid_i,
  input  bus_pkg::bus_req_t lsu_req_i,
  output logic              lsu_req_ready_o,
  output logic              lsu_rsp_valid_o,
  output bus_pkg::bus_rsp_t lsu_rsp_o,
  output logic              mem_req_valid_o,
  output bus_pkg::bus_req_t mem_req_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_rsp_valid_i,
  input  bus_pkg::bus_rsp_t mem_rsp_i,
  output logic              uart_tx_valid_o,
  output logic [7:0]        uart_tx_data_o,
  input  logic              uart_tx_ready_i,
  output logic              timer_irq_o
);

  logic              clint_req_valid;
  bus_pkg::bus_req_t clint_req;
  logic [31:0]       clint_rdata;
  logic              uart_wvalid;
  logic [7:0]        uart_wdata;
  logic              uart_wready;

  bus_arbiter bus_arbiter_inst (
    .clk, .rst,
    .ifu_req_valid_i, .ifu_addr_i, .ifu_req_ready_o, .ifu_rsp_valid_o, .ifu_rsp_o,
    .lsu_req_valid_i, .lsu_req_i, .lsu_req_ready_o, .lsu_rsp_valid_o, .lsu_rsp_o,
    .mem_req_valid_o, .mem_req_o, .mem_req_ready_i, .mem_rsp_valid_i, .mem_rsp_i,
    .clint_req_valid_o (clint_req_valid),
    .clint_req_o       (clint_req),
    .clint_rdata_i     (clint_rdata),
    .uart_wvalid_o     (uart_wvalid),
    .uart_wdata_o      (uart_wdata),
    .uart_wready_i     (uart_wready)
  );

  clint_timer clint_timer_inst (
    .clk, .rst,
    .req_valid_i (clint_req_valid),
    .req_i       (clint_req),
    .rdata_o     (clint_rdata),
    .timer_irq_o
  );

  uart_tx_buffer uart_tx_buffer_inst (
    .clk, .rst,
    .wvalid_i   (uart_wvalid),
    .wdata_i    (uart_wdata),
    .wready_o   (uart_wready),
    .tx_valid_o (uart_tx_valid_o),
    .tx_data_o  (uart_tx_data_o),
    .tx_ready_i (uart_tx_ready_i)
  );

endmodule

//--- design/uart_tx_buffer.sv
module uart_tx_buffer (
  input  logic       clk,
  input  logic       rst,
  input  logic       wvalid_i,
  input  logic [7:0] wdata_i,
  output logic       wready_o,
  output logic       tx_valid_o,
  output logic [7:0] tx_data_o,
  input  logic       tx_ready_i
);

  logic [7:0]                    fifo_mem [map_pkg::UART_FIFO_DEPTH];
  logic [map_pkg::UART_PTR_W-1:0] wr_ptr_q;
  logic [map_pkg::UART_PTR_W-1:0] rd_ptr_q;
  logic [map_pkg::UART_PTR_W:0]   count_q;
  logic                          push;
  logic                          pop;

  // no write while full, even if a byte drains the same cycle
  assign wready_o   = (count_q != (map_pkg::UART_PTR_W+1)'(map_pkg::UART_FIFO_DEPTH));
  assign tx_valid_o = (count_q != '0);
  assign tx_data_o  = fifo_mem[rd_ptr_q];

  assign push = wvalid_i && wready_o;
  assign pop  = tx_valid_o && tx_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == map_pkg::UART_PTR_W'(map_pkg::UART_FIFO_DEPTH - 1)) ? '0
                                                                         : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == map_pkg::UART_PTR_W'(map_pkg::UART_FIFO_DEPTH - 1)) ? '0
                                                                         : rd_ptr_q + 1'b1;
      // simultaneous push and pop leaves the count alone
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      fifo_mem[wr_ptr_q] <= wdata_i;
  end

endmodule

//--- design/clint_timer.sv
module clint_timer (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  input  bus_pkg::bus_req_t req_i,
  output logic [31:0]       rdata_o,
  output logic              timer_irq_o
);

  logic [map_pkg::MTIME_W-1:0] mtime_q;
  logic [map_pkg::MTIME_W-1:0] mtimecmp_q;
  logic                        wr_en;
  logic                        rd_en;

  // merge the enabled byte lanes of a write into the old word
  function automatic logic [31:0] apply_strb(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        merged[8*i +: 8] = new_word[8*i +: 8];
    end
    return merged;
  endfunction

  assign wr_en = req_valid_i && (req_i.op == bus_pkg::OP_WRITE);
  assign rd_en = req_valid_i && (req_i.op == bus_pkg::OP_READ);

  // mtime is read only from the bus
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
    end
    else
    begin
      mtime_q     <= mtime_q + 1'b1;
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      if (wr_en && (req_i.addr == map_pkg::MTIMECMP_LO_ADDR))
        mtimecmp_q[31:0] <= apply_strb(mtimecmp_q[31:0], req_i.wdata, req_i.wstrb);
      if (wr_en && (req_i.addr == map_pkg::MTIMECMP_HI_ADDR))
        mtimecmp_q[63:32] <= apply_strb(mtimecmp_q[63:32], req_i.wdata, req_i.wstrb);
    end
  end

  // read data one cycle after the request
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      case (req_i.addr)
        map_pkg::MTIME_LO_ADDR:    rdata_o <= mtime_q[31:0];
        map_pkg::MTIME_HI_ADDR:    rdata_o <= mtime_q[63:32];
        map_pkg::MTIMECMP_LO_ADDR: rdata_o <= mtimecmp_q[31:0];
        map_pkg::MTIMECMP_HI_ADDR: rdata_o <= mtimecmp_q[63:32];
        default:                   rdata_o <= 32'd0;
      endcase
    end
  end

endmodule

//--- design/bus_arbiter.sv
module bus_arbiter (
  input  logic              clk,
  input  logic              rst,
  // fetch port
  input  logic              ifu_req_valid_i,
  input  logic [31:0]       ifu_addr_i,
  output logic              ifu_req_ready_o,
  output logic              ifu_rsp_valid_o,
  output bus_pkg::bus_rsp_t ifu_rsp_o,
  // load/store port
  input  logic              lsu_req_valid_i,
  input  bus_pkg::bus_req_t lsu_req_i,
  output logic              lsu_req_ready_o,
  output logic              lsu_rsp_valid_o,
  output bus_pkg::bus_rsp_t lsu_rsp_o,
  // external memory
  output logic              mem_req_valid_o,
  output bus_pkg::bus_req_t mem_req_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_rsp_valid_i,
  input  bus_pkg::bus_rsp_t mem_rsp_i,
  // local devices
  output logic              clint_req_valid_o,
  output bus_pkg::bus_req_t clint_req_o,
  input  logic [31:0]       clint_rdata_i,
  output logic              uart_wvalid_o,
  output logic [7:0]        uart_wdata_o,
  input  logic              uart_wready_i
);

  bus_pkg::arb_state_e state_q;
  bus_pkg::arb_state_e state_d;
  bus_pkg::bus_req_t   req_q;
  bus_pkg::bus_rsp_t   rsp_q;
  logic                owner_lsu_q;
  logic                tgt_clint_q;
  logic                mem_done_q;
  logic                idle;
  logic                local_rsp;
  logic                lsu_is_clint;
  logic                lsu_is_uart;
  logic                lsu_fire;
  logic                ifu_fire;
  logic                mem_rsp_take;
  logic [31:0]         local_rdata;

  assign idle      = (state_q == bus_pkg::ST_IDLE);
  assign local_rsp = (state_q == bus_pkg::ST_LOCAL_RSP);

  // timer is matched word by word, load/store only
  assign lsu_is_clint = (lsu_req_i.addr == map_pkg::MTIME_LO_ADDR)
                     || (lsu_req_i.addr == map_pkg::MTIME_HI_ADDR)
                     || (lsu_req_i.addr == map_pkg::MTIMECMP_LO_ADDR)
                     || (lsu_req_i.addr == map_pkg::MTIMECMP_HI_ADDR);
  // serial device takes stores only, a load there falls through to memory
  assign lsu_is_uart = (lsu_req_i.addr == map_pkg::UART_TX_ADDR)
                    && (lsu_req_i.op == bus_pkg::OP_WRITE);

  // full FIFO holds off the store, which also blocks fetch behind it
  assign lsu_req_ready_o = idle && (!lsu_is_uart || uart_wready_i);
  assign ifu_req_ready_o = idle && !lsu_req_valid_i;
  assign lsu_fire        = lsu_req_valid_i && lsu_req_ready_o;
  assign ifu_fire        = ifu_req_valid_i && ifu_req_ready_o;

  assign clint_req_valid_o = lsu_fire && lsu_is_clint;
  assign clint_req_o       = lsu_req_i;
  assign uart_wvalid_o     = idle && lsu_req_valid_i && lsu_is_uart;
  assign uart_wdata_o      = lsu_req_i.wdata[7:0];

  assign mem_req_valid_o = (state_q == bus_pkg::ST_MEM_REQ);
  assign mem_req_o       = req_q;
  assign mem_rsp_take    = (state_q == bus_pkg::ST_MEM_WAIT) && mem_rsp_valid_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      bus_pkg::ST_IDLE:
      begin
        if (lsu_fire)
          state_d = (lsu_is_clint || lsu_is_uart) ? bus_pkg::ST_LOCAL_RSP
                                                  : bus_pkg::ST_MEM_REQ;
        else if (ifu_fire)
          state_d = bus_pkg::ST_MEM_REQ;
      end
      bus_pkg::ST_MEM_REQ:
      begin
        if (mem_req_ready_i)
          state_d = bus_pkg::ST_MEM_WAIT;
      end
      bus_pkg::ST_MEM_WAIT:
      begin
        if (mem_rsp_valid_i)
          state_d = bus_pkg::ST_IDLE;
      end
      default:
        state_d = bus_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= bus_pkg::ST_IDLE;
      owner_lsu_q <= 1'b0;
      tgt_clint_q <= 1'b0;
      mem_done_q  <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      mem_done_q <= mem_rsp_take;
      if (lsu_fire)
      begin
        owner_lsu_q <= 1'b1;
        tgt_clint_q <= lsu_is_clint;
      end
      else if (ifu_fire)
      begin
        owner_lsu_q <= 1'b0;
        tgt_clint_q <= 1'b0;
      end
    end
  end

  // latched request and memory read data
  always_ff @(posedge clk)
  begin
    if (lsu_fire)
      req_q <= lsu_req_i;
    else if (ifu_fire)
      req_q <= '{op: bus_pkg::OP_READ, addr: ifu_addr_i, wdata: 32'd0, wstrb: 4'd0};
    if (mem_rsp_take)
      rsp_q.rdata <= (req_q.op == bus_pkg::OP_READ) ? mem_rsp_i.rdata : 32'd0;
  end

  // timer read data is registered inside the timer, so it is ready here
  assign local_rdata = (tgt_clint_q && (req_q.op == bus_pkg::OP_READ)) ? clint_rdata_i
                                                                         : 32'd0;

  assign lsu_rsp_valid_o = owner_lsu_q && (mem_done_q || local_rsp);
  assign lsu_rsp_o.rdata = !owner_lsu_q ? 32'd0 : (local_rsp ? local_rdata : rsp_q.rdata);
  assign ifu_rsp_valid_o = !owner_lsu_q && mem_done_q;
  assign ifu_rsp_o.rdata = owner_lsu_q ? 32'd0 : rsp_q.rdata;

endmodule

//--- design/map_pkg.sv
package map_pkg;

  // serial transmit register, write only
  localparam logic [31:0] UART_TX_ADDR = 32'hA000_03F8;

  // core-local timer, one word per half
  localparam logic [31:0] MTIME_LO_ADDR    = 32'hA000_0048;
  localparam logic [31:0] MTIME_HI_ADDR    = 32'hA000_004C;
  localparam logic [31:0] MTIMECMP_LO_ADDR = 32'hA000_0050;
  localparam logic [31:0] MTIMECMP_HI_ADDR = 32'hA000_0054;

  // transmit FIFO size in bytes
  localparam int UART_FIFO_DEPTH = 4;

  // pointer width for the transmit FIFO
  localparam int UART_PTR_W = $clog2(UART_FIFO_DEPTH);

  // timer counter width, split into two bus words
  localparam int MTIME_W = 64;

endpackage

//--- design/bus_pkg.sv
package bus_pkg;

  // bus transfer direction
  typedef enum logic
  {
    OP_READ,
    OP_WRITE
  } bus_op_e;

  // arbiter FSM states
  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_MEM_REQ,
    ST_MEM_WAIT,
    ST_LOCAL_RSP
  } arb_state_e;

  // single-beat request, strobes select byte lanes
  typedef struct packed
  {
    bus_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  // read data back to a requester, zero for writes
  typedef struct packed
  {
    logic [31:0] rdata;
  } bus_rsp_t;

endpackage
